// File: Bender.yml
package:
  name: accum_cpu

sources:
  - target: rtl
    files:
      - hw/cpu_pkg.sv
      - hw/word_ram.sv
      - hw/program_counter.sv
      - hw/instr_decoder.sv
      - hw/acc_datapath.sv
      - hw/accum_cpu_top.sv
  - target: test
    files:
      - tb/accum_cpu_tb.sv

// File: hw/acc_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module acc_datapath (
  input  logic              i_clk,
  input  logic              rsta,
  input  logic              i_acc_we,
  input  cpu_pkg::t_alu_sel i_alu_sel,
  input  logic              i_imm_sel,
  input  logic [10:0]       i_operand,   // Raw operand field
  input  cpu_pkg::t_word    i_mem_data,  // Data memory read word
  output cpu_pkg::t_word    o_acc
);

  localparam int P_EXT_W = $bits(cpu_pkg::t_word) - $bits(i_operand);

  cpu_pkg::t_word    imm_ext;     // Sign-extended operand
  logic              ex_we;       // Execute stage controls
  cpu_pkg::t_alu_sel ex_sel;
  logic              ex_imm_sel;
  cpu_pkg::t_word    ex_imm;
  cpu_pkg::t_word    opnd_b;
  cpu_pkg::t_word    acc_nxt;
  cpu_pkg::t_word    acc_q;

  assign imm_ext = {{P_EXT_W{i_operand[10]}}, i_operand};

  //////////////////////////////
  // Execute latch
  //////////////////////////////

  // Captured at the falling edge where the data memory reads this operand
  // Program memory moves on at that same edge
  always_ff @(negedge i_clk) begin
    if (rsta) begin
      ex_we <= 1'b0;
    end else begin
      ex_we <= i_acc_we;
    end
  end

  always_ff @(negedge i_clk) begin
    ex_sel     <= i_alu_sel;
    ex_imm_sel <= i_imm_sel;
    ex_imm     <= imm_ext;
  end

  // Second operand
  assign opnd_b = ex_imm_sel ? ex_imm : i_mem_data;

  always_comb begin
    case (ex_sel)
      cpu_pkg::SEL_MEM: acc_nxt = i_mem_data;
      cpu_pkg::SEL_IMM: acc_nxt = ex_imm;
      cpu_pkg::SEL_ADD: acc_nxt = acc_q + opnd_b;   // Mod 2^16
      default:          acc_nxt = acc_q - opnd_b;
    endcase
  end

  // Commit on the rising edge
  always_ff @(posedge i_clk) begin
    if (rsta) begin
      acc_q <= '0;
    end else if (ex_we) begin
      acc_q <= acc_nxt;
    end
  end

  assign o_acc = acc_q;

endmodule

`default_nettype wire

// File: hw/accum_cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module accum_cpu_top #(
  parameter int P_MEM_DEPTH = cpu_pkg::P_MEM_DEPTH
) (
  input  logic            i_clk,
  input  logic            rsta,
  input  logic            i_run,        // Low while loading
  input  logic            i_prog_we,    // Program write strobe
  input  cpu_pkg::t_paddr i_prog_addr,
  input  cpu_pkg::t_instr i_prog_data,
  output cpu_pkg::t_word  o_acc,
  output logic            o_halt,
  output logic            o_st_we,      // Store taken at the coming falling edge
  output cpu_pkg::t_daddr o_st_addr,
  output cpu_pkg::t_word  o_st_data
);

  logic              fetch_run;   // Last fetch used the counter
  cpu_pkg::t_paddr   pc;
  cpu_pkg::t_paddr   prog_addr;
  cpu_pkg::t_instr   instr;
  logic              acc_we;
  cpu_pkg::t_alu_sel alu_sel;
  logic              imm_sel;
  logic              mem_we;
  logic              halt;
  cpu_pkg::t_daddr   data_addr;
  cpu_pkg::t_word    mem_rdata;
  cpu_pkg::t_word    acc;

  // Address types are sized for the package depth
  if ($clog2(P_MEM_DEPTH) != $bits(cpu_pkg::t_paddr)) begin : g_depth_check
    $error("P_MEM_DEPTH does not match cpu_pkg address width");
  end

  //////////////////////////////
  // Fetch
  //////////////////////////////

  assign prog_addr = i_run ? pc : i_prog_addr;  // Load port or counter

  // Same edge as the program read, so i_run may rise on any falling edge
  always_ff @(negedge i_clk) begin
    if (rsta) begin
      fetch_run <= 1'b0;
    end else begin
      fetch_run <= i_run;
    end
  end

  word_ram #(
    .P_DEPTH   (P_MEM_DEPTH),
    .t_payload (cpu_pkg::t_instr)
  ) prog_mem_i (
    .i_clk  (i_clk),
    .i_we   (i_prog_we),
    .i_addr (prog_addr),
    .i_data (i_prog_data),
    .o_data (instr)
  );

  program_counter pc_i (
    .i_clk  (i_clk),
    .rsta   (rsta),
    .i_run  (fetch_run),
    .i_halt (halt),
    .o_pc   (pc)
  );

  //////////////////////////////
  // Decode and execute
  //////////////////////////////

  instr_decoder dec_i (
    .i_clk     (i_clk),
    .rsta      (rsta),
    .i_run     (fetch_run),
    .i_instr   (instr),
    .o_acc_we  (acc_we),
    .o_alu_sel (alu_sel),
    .o_imm_sel (imm_sel),
    .o_mem_we  (mem_we),
    .o_halt    (halt)
  );

  assign data_addr = instr.operand[$bits(cpu_pkg::t_daddr)-1:0];  // Direct address

  // Loads read and stores write at the falling edge that ends the decode
  word_ram #(
    .P_DEPTH   (P_MEM_DEPTH),
    .t_payload (cpu_pkg::t_word)
  ) data_mem_i (
    .i_clk  (i_clk),
    .i_we   (mem_we),
    .i_addr (data_addr),
    .i_data (acc),
    .o_data (mem_rdata)
  );

  acc_datapath dp_i (
    .i_clk      (i_clk),
    .rsta       (rsta),
    .i_acc_we   (acc_we),
    .i_alu_sel  (alu_sel),
    .i_imm_sel  (imm_sel),
    .i_operand  (instr.operand),
    .i_mem_data (mem_rdata),
    .o_acc      (acc)
  );

  // Store port mirrors the data memory write, valid up to that falling edge
  assign o_st_we   = mem_we;
  assign o_st_addr = data_addr;
  assign o_st_data = acc;
  assign o_acc     = acc;
  assign o_halt    = halt;

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int P_MEM_DEPTH = 1024;  // Entries per memory

  typedef logic [15:0] t_word;                           // Data word
  typedef logic [$clog2(P_MEM_DEPTH)-1:0] t_daddr;       // Data address
  typedef logic [$clog2(P_MEM_DEPTH)-1:0] t_paddr;       // Program address

  //////////////////////////////
  // Instruction format
  //////////////////////////////

  // Codes 8 to 31 decode as halt
  typedef enum logic [4:0] {
    OP_HLT  = 5'd0,
    OP_STO  = 5'd1,  // mem[op] <= acc
    OP_LD   = 5'd2,  // acc <= mem[op]
    OP_LDI  = 5'd3,  // acc <= sext(op)
    OP_ADD  = 5'd4,
    OP_ADDI = 5'd5,
    OP_SUB  = 5'd6,
    OP_SUBI = 5'd7
  } t_opcode;

  typedef struct packed {
    t_opcode     opcode;   // Bits 15..11
    logic [10:0] operand;  // Immediate or direct address
  } t_instr;

  // Accumulator source
  typedef enum logic [1:0] {
    SEL_MEM,
    SEL_IMM,
    SEL_ADD,
    SEL_SUB
  } t_alu_sel;

endpackage

`default_nettype wire

// File: hw/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
  input  logic              i_clk,
  input  logic              rsta,
  input  logic              i_run,      // Instruction on i_instr is a real fetch
  input  cpu_pkg::t_instr   i_instr,    // From program memory
  output logic              o_acc_we,   // Accumulator update for this instruction
  output cpu_pkg::t_alu_sel o_alu_sel,
  output logic              o_imm_sel,  // Immediate as second operand
  output logic              o_mem_we,   // Store at the coming falling edge
  output logic              o_halt
);

  logic halt_q;      // Sticky halt
  logic active;      // Enables allowed
  logic dec_acc_we;
  logic dec_mem_we;
  logic dec_halt;

  assign active = i_run && !halt_q;

  //////////////////////////////
  // Opcode decode
  //////////////////////////////

  always_comb begin
    dec_acc_we = 1'b0;
    dec_mem_we = 1'b0;
    dec_halt   = 1'b0;
    o_alu_sel  = cpu_pkg::SEL_MEM;
    o_imm_sel  = 1'b0;
    case (i_instr.opcode)
      cpu_pkg::OP_STO: dec_mem_we = 1'b1;
      cpu_pkg::OP_LD: dec_acc_we = 1'b1;   // Memory word straight in
      cpu_pkg::OP_LDI: begin
        dec_acc_we = 1'b1;
        o_alu_sel  = cpu_pkg::SEL_IMM;
        o_imm_sel  = 1'b1;
      end
      cpu_pkg::OP_ADD, cpu_pkg::OP_ADDI: begin
        dec_acc_we = 1'b1;
        o_alu_sel  = cpu_pkg::SEL_ADD;
        o_imm_sel  = (i_instr.opcode == cpu_pkg::OP_ADDI);
      end
      cpu_pkg::OP_SUB, cpu_pkg::OP_SUBI: begin
        dec_acc_we = 1'b1;
        o_alu_sel  = cpu_pkg::SEL_SUB;
        o_imm_sel  = (i_instr.opcode == cpu_pkg::OP_SUBI);
      end
      default: dec_halt = 1'b1;  // OP_HLT and every unused code
    endcase
  end

  assign o_acc_we = active && dec_acc_we;
  assign o_mem_we = active && dec_mem_we;

  // Halt takes effect at the next rising edge and holds until reset
  always_ff @(posedge i_clk) begin
    if (rsta) begin
      halt_q <= 1'b0;
    end else if (active && dec_halt) begin
      halt_q <= 1'b1;
    end
  end

  assign o_halt = halt_q;

  a_we_exclusive: assert property (
    @(posedge i_clk) disable iff (rsta) !(o_mem_we && o_acc_we)
  ) else $error("store and accumulator load decoded together");

endmodule

`default_nettype wire

// File: hw/program_counter.sv
`timescale 1ns/100ps
`default_nettype none

module program_counter (
  input  logic            i_clk,
  input  logic            rsta,
  input  logic            i_run,   // Current instruction was fetched by the counter
  input  logic            i_halt,  // Freeze
  output cpu_pkg::t_paddr o_pc
);

  cpu_pkg::t_paddr pc_q;

  // One step per rising edge while executing
  always_ff @(posedge i_clk) begin
    if (rsta) begin
      pc_q <= '0;               // Program starts at address 0
    end else if (i_run && !i_halt) begin
      pc_q <= pc_q + 1'b1;      // Wraps at the end of program space
    end
  end

  assign o_pc = pc_q;

  // Halted counter does not move until reset
  a_pc_frozen: assert property (
    @(posedge i_clk) disable iff (rsta) i_halt |=> $stable(o_pc)
  ) else $error("program counter moved while halted");

endmodule

`default_nettype wire

// File: hw/word_ram.sv
`timescale 1ns/100ps
`default_nettype none

module word_ram #(
  parameter int  P_DEPTH   = 1024,
  parameter type t_payload = logic [15:0]
) (
  input  logic                       i_clk,
  input  logic                       i_we,    // Write instead of read
  input  logic [$clog2(P_DEPTH)-1:0] i_addr,
  input  t_payload                   i_data,
  output t_payload                   o_data   // Valid from one falling edge to the next
);

  localparam int P_WIDTH = $bits(t_payload);

  t_payload mem [P_DEPTH];  // Storage array
  t_payload rd_q;           // Read register

  // Each entry starts out holding its own index
  // Program words below 2048 carry opcode 0, so unwritten program space halts
  initial begin
    for (int i = 0; i < P_DEPTH; i++) begin
      mem[i] = P_WIDTH'(i);
    end
  end

  //////////////////////////////
  // Falling-edge port
  //////////////////////////////

  // No-change mode
  // A write leaves the read register as it was
  always @(negedge i_clk) begin
    if (i_we) begin
      mem[i_addr] <= i_data;  // Write
    end else begin
      rd_q <= mem[i_addr];    // Read
    end
  end

  assign o_data = rd_q;  // No output register, one falling edge of latency

  // Writes stay inside the array
  a_wr_in_range: assert property (
    @(negedge i_clk) i_we |-> (i_addr < P_DEPTH)
  ) else $error("word_ram write address %0d out of range", i_addr);

endmodule

`default_nettype wire

// File: sources.f
hw/cpu_pkg.sv
hw/word_ram.sv
hw/program_counter.sv
hw/instr_decoder.sv
hw/acc_datapath.sv
hw/accum_cpu_top.sv
tb/accum_cpu_tb.sv

// File: tb/accum_cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module accum_cpu_tb;

  localparam int P_RUNS         = 10;
  localparam int P_HLT_ONLY_RUN = 4;    // Program of a lone halt
  localparam int P_HALT_TIMEOUT = 200;  // Cycles from start to halt
  localparam int P_HOLD_CYCLES  = 20;   // Quiet cycles checked after halt

  logic            i_clk;
  logic            rsta;
  logic            i_run;
  logic            i_prog_we;
  cpu_pkg::t_paddr i_prog_addr;
  cpu_pkg::t_instr i_prog_data;
  cpu_pkg::t_word  o_acc;
  logic            o_halt;
  logic            o_st_we;
  cpu_pkg::t_daddr o_st_addr;
  cpu_pkg::t_word  o_st_data;

  cpu_pkg::t_word  model_mem [cpu_pkg::P_MEM_DEPTH];  // Kept across runs as in the DUT
  cpu_pkg::t_word  model_acc;
  cpu_pkg::t_instr prog [$];
  cpu_pkg::t_daddr exp_addr [$];                      // Expected stores, in order
  cpu_pkg::t_word  exp_data [$];

  accum_cpu_top #(
    .P_MEM_DEPTH (cpu_pkg::P_MEM_DEPTH)
  ) accum_cpu_top_i (
    .i_clk       (i_clk),
    .rsta        (rsta),
    .i_run       (i_run),
    .i_prog_we   (i_prog_we),
    .i_prog_addr (i_prog_addr),
    .i_prog_data (i_prog_data),
    .o_acc       (o_acc),
    .o_halt      (o_halt),
    .o_st_we     (o_st_we),
    .o_st_addr   (o_st_addr),
    .o_st_data   (o_st_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;  // 100 ns period
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic stop_failed();
    $display("Testbench failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(string name, cpu_pkg::t_word exp, cpu_pkg::t_word act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_addr(string name, cpu_pkg::t_daddr exp, cpu_pkg::t_daddr act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_flag(string name, bit exp, logic act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      stop_failed();
    end
  endtask

  //////////////////////////////
  // Program and model
  //////////////////////////////

  function automatic cpu_pkg::t_word sext11(logic [10:0] op);
    return cpu_pkg::t_word'($signed(op));  // Two's complement value kept
  endfunction

  task automatic gen_program(bit hlt_only);
    int              n;
    int              code;
    logic [10:0]     operand;
    cpu_pkg::t_instr ins;
    prog.delete();
    n = hlt_only ? 0 : $urandom_range(4, 40);
    for (int i = 0; i < n; i++) begin
      code    = ($urandom_range(0, 31) == 0) ? 0 : $urandom_range(1, 7);  // Rare early halt
      operand = 11'($urandom);
      if ($urandom_range(0, 1) == 1) begin
        operand[9:0] = 10'($urandom_range(0, 7));  // Few hot addresses so loads see stores
      end
      ins.opcode  = cpu_pkg::t_opcode'(code);
      ins.operand = operand;
      prog.push_back(ins);
    end
    ins.opcode  = cpu_pkg::OP_HLT;
    ins.operand = '0;
    prog.push_back(ins);
  endtask

  // Instruction-set model that runs to the first halt
  task automatic run_model();
    logic [10:0]     op;
    cpu_pkg::t_daddr addr;
    model_acc = '0;  // Reset value
    exp_addr.delete();
    exp_data.delete();
    foreach (prog[i]) begin
      op   = prog[i].operand;
      addr = op[9:0];  // Direct address
      case (prog[i].opcode)
        cpu_pkg::OP_STO: begin
          exp_addr.push_back(addr);
          exp_data.push_back(model_acc);
          model_mem[addr] = model_acc;
        end
        cpu_pkg::OP_LD:   model_acc = model_mem[addr];
        cpu_pkg::OP_LDI:  model_acc = sext11(op);
        cpu_pkg::OP_ADD:  model_acc = model_acc + model_mem[addr];  // Wraps at 16 bits
        cpu_pkg::OP_ADDI: model_acc = model_acc + sext11(op);
        cpu_pkg::OP_SUB:  model_acc = model_acc - model_mem[addr];
        cpu_pkg::OP_SUBI: model_acc = model_acc - sext11(op);
        default: break;
      endcase
    end
  endtask

  //////////////////////////////
  // DUT sequences
  //////////////////////////////

  task automatic apply_reset();
    @(negedge i_clk);
    rsta      <= 1'b1;
    i_run     <= 1'b0;
    i_prog_we <= 1'b0;
    repeat (5) @(negedge i_clk);
    rsta <= 1'b0;
  endtask

  task automatic load_program();
    foreach (prog[i]) begin
      @(negedge i_clk);
      check_flag("store while loading", 1'b0, o_st_we);
      i_prog_we   <= 1'b1;
      i_prog_addr <= cpu_pkg::t_paddr'(i);
      i_prog_data <= prog[i];
    end
    @(negedge i_clk);  // Last word written here
    i_prog_we <= 1'b0;
  endtask

  task automatic run_and_check(string name);
    int cycles;
    @(negedge i_clk);
    i_run <= 1'b1;
    // Sampled on falling edges half a cycle after any rising-edge update
    for (cycles = 0; o_halt !== 1'b1; cycles++) begin
      if (cycles == P_HALT_TIMEOUT) begin
        $display("Timeout in %s: processor did not halt", name);
        stop_failed();
      end
      @(negedge i_clk);
      if (o_st_we === 1'b1) begin
        if (exp_addr.size() == 0) begin
          $display("Error in %s: store with no matching store instruction", name);
          stop_failed();
        end
        check_addr({name, " store address"}, exp_addr.pop_front(), o_st_addr);
        check_word({name, " store data"}, exp_data.pop_front(), o_st_data);
      end
    end
    if (exp_addr.size() != 0) begin
      $display("Error in %s: %0d stores missing at halt", name, exp_addr.size());
      stop_failed();
    end
    check_word({name, " final accumulator"}, model_acc, o_acc);
    repeat (P_HOLD_CYCLES) begin  // Frozen after halt
      @(negedge i_clk);
      check_flag({name, " halt held"}, 1'b1, o_halt);
      check_flag({name, " store after halt"}, 1'b0, o_st_we);
      check_word({name, " accumulator after halt"}, model_acc, o_acc);
    end
  endtask

  //////////////////////////////
  // Main
  //////////////////////////////

  initial begin
    void'($urandom(4816));
    rsta        = 1'b1;
    i_run       = 1'b0;
    i_prog_we   = 1'b0;
    i_prog_addr = '0;
    i_prog_data = '0;
    for (int i = 0; i < cpu_pkg::P_MEM_DEPTH; i++) begin
      model_mem[i] = cpu_pkg::t_word'(i);  // Index fill, as the data memory
    end
    for (int run = 0; run < P_RUNS; run++) begin
      gen_program(run == P_HLT_ONLY_RUN);
      apply_reset();
      @(negedge i_clk);
      check_flag($sformatf("run %0d halt after reset", run), 1'b0, o_halt);
      check_flag($sformatf("run %0d store after reset", run), 1'b0, o_st_we);
      load_program();
      run_model();
      run_and_check($sformatf("run %0d", run));
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
